/* flist.f */
hw/rob_pkg.sv
hw/rename_stage.sv
hw/rob_module.sv
hw/arch_regfile.sv
hw/rob_core_top.sv
bench/tb_clock_gen.sv
bench/rob_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= rob_core_tb
RTL_TOP   ?= rob_core_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= Simulation completed successfully

RTL_SRCS := $(shell grep '^hw/' $(FLIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

/* bench/rob_core_tb.sv */
`timescale 1ns/100ps

module rob_core_tb;

  localparam int TIMEOUT = 40;

  logic                  in_clk;
  logic                  in_rst_n;
  logic                  issue_valid;
  rob_pkg::issue_instr_t issue_instr;
  logic                  issue_ready;
  logic                  fu_valid;
  rob_pkg::fu_result_t   fu_result;
  logic                  rs_valid;
  rob_pkg::rs_dispatch_t rs_dispatch;
  logic                  bcast_valid;
  rob_pkg::broadcast_t   bcast;
  logic                  commit_valid;
  rob_pkg::commit_t      commit;

  // Reference model of architectural state, status table and ROB
  rob_pkg::gpr_val_t m_gpr   [rob_pkg::GPR_COUNT];
  logic              m_pend  [rob_pkg::GPR_COUNT];
  rob_pkg::rob_idx_t m_tag   [rob_pkg::GPR_COUNT];
  rob_pkg::nzcv_t    m_nzcv;
  logic              m_nzcv_pend;
  rob_pkg::rob_idx_t m_nzcv_tag;
  logic              m_done  [rob_pkg::ROB_DEPTH];
  rob_pkg::gpr_idx_t m_dst   [rob_pkg::ROB_DEPTH];
  rob_pkg::gpr_val_t m_val   [rob_pkg::ROB_DEPTH];
  logic              m_setf  [rob_pkg::ROB_DEPTH];
  rob_pkg::nzcv_t    m_flags [rob_pkg::ROB_DEPTH];
  rob_pkg::rob_idx_t m_head;
  rob_pkg::rob_idx_t m_tail;
  int                m_count;

  // What the DUT must show at the next falling edge
  logic                  exp_rs;
  rob_pkg::rs_dispatch_t exp_rs_d;
  logic                  exp_bc;
  rob_pkg::rob_idx_t     exp_bc_idx;

  integer seed;
  string  test_name;
  int     errors;
  int     test_errors;
  int     tests_run;
  int     waited;

  tb_clock_gen clock_gen (
    .in_clk   (in_clk),
    .in_rst_n (in_rst_n)
  );

  rob_core_top UUT (
    .in_clk       (in_clk),
    .in_rst_n     (in_rst_n),
    .issue_valid  (issue_valid),
    .issue_instr  (issue_instr),
    .issue_ready  (issue_ready),
    .fu_valid     (fu_valid),
    .fu_result    (fu_result),
    .rs_valid     (rs_valid),
    .rs_dispatch  (rs_dispatch),
    .bcast_valid  (bcast_valid),
    .bcast        (bcast),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

  task automatic check(input string what, input logic [63:0] exp_v, input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("TIMEOUT in %s: %s never came", test_name, what);
    errors++;
    test_errors++;
  endtask

  task automatic check_gpr_opnd(input string what, input rob_pkg::gpr_opnd_t exp_o,
                                input rob_pkg::gpr_opnd_t act_o);
    check({what, " valid"}, exp_o.valid, act_o.valid);
    if (exp_o.valid) begin
      check({what, " value"}, exp_o.value, act_o.value);
    end else begin
      check({what, " rob index"}, exp_o.rob_index, act_o.rob_index);  // Producer tag
    end
  endtask

  // Register file value, or the producer's result once it is done
  function automatic rob_pkg::gpr_opnd_t expect_gpr(input rob_pkg::gpr_idx_t r);
    rob_pkg::gpr_opnd_t o;
    o.rob_index = m_tag[r];
    o.valid     = !m_pend[r] || m_done[m_tag[r]];
    o.value     = m_pend[r] ? m_val[m_tag[r]] : m_gpr[r];
    return o;
  endfunction

  function automatic rob_pkg::nzcv_opnd_t expect_nzcv();
    rob_pkg::nzcv_opnd_t o;
    o.rob_index = m_nzcv_tag;
    o.valid     = !m_nzcv_pend || m_done[m_nzcv_tag];
    o.flags     = m_nzcv_pend ? m_flags[m_nzcv_tag] : m_nzcv;
    return o;
  endfunction

  function automatic rob_pkg::issue_instr_t make_instr(
    input rob_pkg::gpr_idx_t dst,
    input rob_pkg::gpr_idx_t src1,
    input rob_pkg::gpr_idx_t src2,
    input logic              set_f,
    input logic              use_f
  );
    return '{dst: dst, src1: src1, src2: src2, set_nzcv: set_f, uses_nzcv: use_f,
             fu_id: dst[1:0], fu_op: src1[3:0], cond: src2[3:0]};
  endfunction

  // One clock; compares every output with the model, then drops the strobes
  task automatic tick();
    logic exp_commit;
    @(negedge in_clk);
    check("issue_ready", m_count < rob_pkg::ROB_DEPTH, issue_ready);
    check("rs_valid", exp_rs, rs_valid);
    if (exp_rs && rs_valid) begin
      check("dst rob index", exp_rs_d.dst_rob_index, rs_dispatch.dst_rob_index);
      check_gpr_opnd("src1", exp_rs_d.src1, rs_dispatch.src1);
      check_gpr_opnd("src2", exp_rs_d.src2, rs_dispatch.src2);
      check("nzcv valid", exp_rs_d.nzcv.valid, rs_dispatch.nzcv.valid);
      if (exp_rs_d.nzcv.valid) begin
        check("nzcv flags", exp_rs_d.nzcv.flags, rs_dispatch.nzcv.flags);
      end else begin
        check("nzcv rob index", exp_rs_d.nzcv.rob_index, rs_dispatch.nzcv.rob_index);
      end
      check("controls", {exp_rs_d.set_nzcv, exp_rs_d.uses_nzcv, exp_rs_d.fu_id,
                         exp_rs_d.fu_op, exp_rs_d.cond},
            {rs_dispatch.set_nzcv, rs_dispatch.uses_nzcv, rs_dispatch.fu_id,
             rs_dispatch.fu_op, rs_dispatch.cond});
    end
    check("bcast_valid", exp_bc, bcast_valid);
    if (exp_bc && bcast_valid) begin
      check("bcast index", exp_bc_idx, bcast.rob_index);
      check("bcast value", m_val[exp_bc_idx], bcast.value);
      check("bcast flags", {m_setf[exp_bc_idx], m_flags[exp_bc_idx]},
            {bcast.set_nzcv, bcast.nzcv});
    end
    // Head retires exactly when it is done
    exp_commit = m_count > 0 && m_done[m_head];
    check("commit_valid", exp_commit, commit_valid);
    if (exp_commit && commit_valid) begin
      check("commit rob index", m_head, commit.rob_index);
      check("commit gpr", m_dst[m_head], commit.gpr_index);
      check("commit value", m_val[m_head], commit.value);
      check("commit flags", {m_setf[m_head], m_flags[m_head]}, {commit.set_nzcv, commit.nzcv});
      m_gpr[m_dst[m_head]] = m_val[m_head];
      if (m_setf[m_head]) begin
        m_nzcv = m_flags[m_head];
      end
      if (m_tag[m_dst[m_head]] == m_head) begin
        m_pend[m_dst[m_head]] = 1'b0;  // Only the latest producer clears
      end
      if (m_setf[m_head] && m_nzcv_tag == m_head) begin
        m_nzcv_pend = 1'b0;
      end
      m_done[m_head] = 1'b0;
      m_head         = m_head + 1'b1;
      m_count--;
    end
    exp_rs      = 1'b0;
    exp_bc      = 1'b0;
    issue_valid = 1'b0;
    fu_valid    = 1'b0;
  endtask

  task automatic issue(input rob_pkg::gpr_idx_t dst, input rob_pkg::gpr_idx_t src1,
                       input rob_pkg::gpr_idx_t src2, input logic set_f, input logic use_f,
                       output rob_pkg::rob_idx_t idx);
    rob_pkg::issue_instr_t ins;
    int n;
    ins = make_instr(dst, src1, src2, set_f, use_f);
    n   = 0;
    while (!issue_ready && n < TIMEOUT) begin  // Held on the bus while full
      issue_valid = 1'b1;
      issue_instr = ins;
      tick();
      n++;
    end
    idx = m_tail;
    if (!issue_ready) begin
      report_timeout("issue_ready");
    end else begin
      issue_valid               = 1'b1;
      issue_instr               = ins;
      exp_rs                    = 1'b1;
      exp_rs_d.dst_rob_index    = m_tail;
      exp_rs_d.src1             = expect_gpr(src1);
      exp_rs_d.src2             = expect_gpr(src2);
      exp_rs_d.nzcv             = expect_nzcv();
      exp_rs_d.set_nzcv         = ins.set_nzcv;
      exp_rs_d.uses_nzcv        = ins.uses_nzcv;
      exp_rs_d.fu_id            = ins.fu_id;
      exp_rs_d.fu_op            = ins.fu_op;
      exp_rs_d.cond             = ins.cond;
      // Sources looked up above, now the destination maps to the new slot
      m_pend[dst] = 1'b1;
      m_tag[dst]  = m_tail;
      if (set_f) begin
        m_nzcv_pend = 1'b1;
        m_nzcv_tag  = m_tail;
      end
      m_done[m_tail]  = 1'b0;
      m_dst[m_tail]   = dst;
      m_setf[m_tail]  = set_f;
      m_flags[m_tail] = '0;
      m_tail          = m_tail + 1'b1;
      m_count++;
      tick();
    end
  endtask

  task automatic complete(input rob_pkg::rob_idx_t idx, input rob_pkg::nzcv_t flags,
                          output rob_pkg::gpr_val_t v);
    v                  = {$random(seed), $random(seed)};
    fu_valid           = 1'b1;
    fu_result.rob_index = idx;
    fu_result.value    = v;
    fu_result.set_nzcv = m_setf[idx];
    fu_result.nzcv     = flags;
    m_done[idx]        = 1'b1;
    m_val[idx]         = v;
    if (m_setf[idx]) begin
      m_flags[idx] = flags;
    end
    exp_bc     = 1'b1;
    exp_bc_idx = idx;
    tick();
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (m_count > 0 && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (m_count > 0) begin
      report_timeout("commit_valid for every entry");
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic end_test();
    $display("%-16s %0d errors", test_name, test_errors);
  endtask

  task automatic test_reset_state();
    rob_pkg::rob_idx_t idx;
    rob_pkg::gpr_val_t v;
    start_test("reset_state");
    check("issue_ready", 1, issue_ready);
    check("rs_valid", 0, rs_valid);
    check("bcast_valid", 0, bcast_valid);
    check("commit_valid", 0, commit_valid);
    issue(5'd1, 5'd7, 5'd31, 1'b0, 1'b1, idx);  // Zero registers and zero flags
    check("first index", 0, rs_dispatch.dst_rob_index);
    complete(idx, 4'h0, v);
    drain();
    end_test();
  endtask

  task automatic test_single_flow();
    rob_pkg::rob_idx_t idx;
    rob_pkg::gpr_val_t v;
    start_test("single_flow");
    issue(5'd3, 5'd0, 5'd1, 1'b0, 1'b0, idx);
    complete(idx, 4'h0, v);
    drain();
    issue(5'd4, 5'd3, 5'd3, 1'b0, 1'b0, idx);  // Reads the committed r3
    complete(idx, 4'h0, v);
    drain();
    end_test();
  endtask

  task automatic test_dependency();
    rob_pkg::rob_idx_t blk;
    rob_pkg::rob_idx_t prod;
    rob_pkg::rob_idx_t c1;
    rob_pkg::rob_idx_t c2;
    rob_pkg::gpr_val_t v;
    start_test("dependency");
    issue(5'd6, 5'd0, 5'd0, 1'b0, 1'b0, blk);  // Keeps the head busy
    issue(5'd7, 5'd0, 5'd0, 1'b0, 1'b0, prod);
    issue(5'd8, 5'd7, 5'd0, 1'b0, 1'b0, c1);
    complete(prod, 4'h0, v);
    issue(5'd9, 5'd7, 5'd7, 1'b0, 1'b0, c2);   // Producer done, not committed
    complete(blk, 4'h0, v);
    complete(c1, 4'h0, v);
    complete(c2, 4'h0, v);
    drain();
    end_test();
  endtask

  task automatic test_out_of_order();
    rob_pkg::rob_idx_t ids [4];
    rob_pkg::gpr_val_t v;
    start_test("out_of_order");
    for (int i = 0; i < 4; i++) begin
      issue(rob_pkg::gpr_idx_t'(10 + i), 5'd3, 5'd4, 1'b0, 1'b0, ids[i]);
    end
    for (int i = 3; i >= 0; i--) begin
      complete(ids[i], 4'h0, v);
    end
    drain();
    end_test();
  endtask

  task automatic test_full();
    rob_pkg::rob_idx_t ids [rob_pkg::ROB_DEPTH];
    rob_pkg::rob_idx_t late;
    rob_pkg::gpr_val_t v;
    start_test("full_rob");
    for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
      issue(rob_pkg::gpr_idx_t'(12 + i), rob_pkg::gpr_idx_t'(i), 5'd9, 1'b0, 1'b0, ids[i]);
    end
    check("issue_ready when full", 0, issue_ready);
    for (int i = 0; i < 3; i++) begin
      issue_valid = 1'b1;
      issue_instr = make_instr(5'd22, 5'd12, 5'd13, 1'b0, 1'b0);
      tick();  // rs_valid must stay low
    end
    complete(ids[0], 4'h0, v);
    issue(5'd22, 5'd12, 5'd13, 1'b0, 1'b0, late);
    check("freed index", ids[0], rs_dispatch.dst_rob_index);
    for (int i = 1; i < rob_pkg::ROB_DEPTH; i++) begin
      complete(ids[i], 4'h0, v);
    end
    complete(late, 4'h0, v);
    drain();
    end_test();
  endtask

  task automatic test_flags();
    rob_pkg::rob_idx_t f;
    rob_pkg::rob_idx_t r;
    rob_pkg::gpr_val_t v;
    start_test("flags");
    issue(5'd13, 5'd0, 5'd0, 1'b1, 1'b0, f);
    issue(5'd14, 5'd13, 5'd0, 1'b0, 1'b1, r);  // Flags still pending on f
    complete(f, 4'b1010, v);
    complete(r, 4'b0101, v);
    drain();
    issue(5'd15, 5'd0, 5'd0, 1'b0, 1'b1, r);
    complete(r, 4'h0, v);
    drain();
    end_test();
  endtask

  initial begin
    issue_valid = 1'b0;
    issue_instr = '0;
    fu_valid    = 1'b0;
    fu_result   = '0;
    seed        = 32'h3a5f;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    test_name   = "reset";
    exp_rs      = 1'b0;
    exp_rs_d    = '0;
    exp_bc      = 1'b0;
    exp_bc_idx  = '0;
    m_nzcv      = '0;
    m_nzcv_pend = 1'b0;
    m_nzcv_tag  = '0;
    m_head      = '0;
    m_tail      = '0;
    m_count     = 0;
    for (int i = 0; i < rob_pkg::GPR_COUNT; i++) begin
      m_gpr[i]  = '0;
      m_pend[i] = 1'b0;
      m_tag[i]  = '0;
    end
    for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
      m_done[i]  = 1'b0;
      m_dst[i]   = '0;
      m_val[i]   = '0;
      m_setf[i]  = 1'b0;
      m_flags[i] = '0;
    end
    waited = 0;
    @(posedge in_clk);
    while (in_rst_n !== 1'b1 && waited < TIMEOUT) begin
      @(posedge in_clk);
      waited++;
    end
    if (in_rst_n !== 1'b1) begin
      report_timeout("reset release");
    end
    @(negedge in_clk);
    test_reset_state();
    test_single_flow();
    test_dependency();
    test_out_of_order();
    test_full();
    test_flags();
    $display("%0d tests, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic in_clk,
  output logic in_rst_n
);

  initial begin
    in_clk = 1'b0;
    forever #5 in_clk = ~in_clk;  // 10 ns period
  end

  // Low for three full periods, released on a falling edge
  initial begin
    in_rst_n = 1'b0;
    repeat (3) @(negedge in_clk);
    in_rst_n = 1'b1;
  end

endmodule

/* hw/rob_core_top.sv */
`timescale 1ns/100ps

module rob_core_top (
  input  logic                  in_clk,
  input  logic                  in_rst_n,
  input  logic                  issue_valid,
  input  rob_pkg::issue_instr_t issue_instr,
  output logic                  issue_ready,
  input  logic                  fu_valid,
  input  rob_pkg::fu_result_t   fu_result,
  output logic                  rs_valid,
  output rob_pkg::rs_dispatch_t rs_dispatch,
  output logic                  bcast_valid,
  output rob_pkg::broadcast_t   bcast,
  output logic                  commit_valid,
  output rob_pkg::commit_t      commit
);

  logic                 rob_ready;
  rob_pkg::rob_idx_t    next_rob_index;
  logic                 alloc_valid;
  rob_pkg::rename_req_t rename_req;
  rob_pkg::gpr_idx_t    rd_src1_idx;
  rob_pkg::gpr_idx_t    rd_src2_idx;
  rob_pkg::gpr_val_t    rd_src1_value;
  rob_pkg::gpr_val_t    rd_src2_value;
  rob_pkg::nzcv_t       rd_nzcv;

  rename_stage u_rename (
    .in_clk         (in_clk),
    .in_rst_n       (in_rst_n),
    .issue_valid    (issue_valid),
    .issue_instr    (issue_instr),
    .issue_ready    (issue_ready),
    .rob_ready      (rob_ready),
    .next_rob_index (next_rob_index),
    .alloc_valid    (alloc_valid),
    .rename_req     (rename_req),
    .rd_src1_idx    (rd_src1_idx),
    .rd_src2_idx    (rd_src2_idx),
    .rd_src1_value  (rd_src1_value),
    .rd_src2_value  (rd_src2_value),
    .rd_nzcv        (rd_nzcv),
    .commit_valid   (commit_valid),
    .commit         (commit)
  );

  rob_module u_rob (
    .in_clk         (in_clk),
    .in_rst_n       (in_rst_n),
    .alloc_valid    (alloc_valid),
    .rename_req     (rename_req),
    .next_rob_index (next_rob_index),
    .rob_ready      (rob_ready),
    .fu_valid       (fu_valid),
    .fu_result      (fu_result),
    .rs_valid       (rs_valid),
    .rs_dispatch    (rs_dispatch),
    .bcast_valid    (bcast_valid),
    .bcast          (bcast),
    .commit_valid   (commit_valid),
    .commit         (commit)
  );

  // Commits feed both the register file and the status table
  arch_regfile u_regfile (
    .in_clk        (in_clk),
    .in_rst_n      (in_rst_n),
    .commit_valid  (commit_valid),
    .commit        (commit),
    .rd_src1_idx   (rd_src1_idx),
    .rd_src2_idx   (rd_src2_idx),
    .rd_src1_value (rd_src1_value),
    .rd_src2_value (rd_src2_value),
    .rd_nzcv       (rd_nzcv)
  );

endmodule

/* hw/arch_regfile.sv */
`timescale 1ns/100ps

module arch_regfile (
  input  logic              in_clk,
  input  logic              in_rst_n,
  input  logic              commit_valid,
  input  rob_pkg::commit_t  commit,
  input  rob_pkg::gpr_idx_t rd_src1_idx,
  input  rob_pkg::gpr_idx_t rd_src2_idx,
  output rob_pkg::gpr_val_t rd_src1_value,
  output rob_pkg::gpr_val_t rd_src2_value,
  output rob_pkg::nzcv_t    rd_nzcv
);

  rob_pkg::gpr_val_t gpr_q [rob_pkg::GPR_COUNT];
  rob_pkg::nzcv_t    nzcv_q;

  // Architectural state, updated in program order only
  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      nzcv_q <= '0;
      for (int i = 0; i < rob_pkg::GPR_COUNT; i++) begin
        gpr_q[i] <= '0;
      end
    end else if (commit_valid) begin
      gpr_q[commit.gpr_index] <= commit.value;
      if (commit.set_nzcv) begin
        nzcv_q <= commit.nzcv;  // Flags only from flag setters
      end
    end
  end

  // Asynchronous reads for rename
  assign rd_src1_value = gpr_q[rd_src1_idx];
  assign rd_src2_value = gpr_q[rd_src2_idx];
  assign rd_nzcv       = nzcv_q;

endmodule

/* hw/rob_module.sv */
`timescale 1ns/100ps

module rob_module (
  input  logic                  in_clk,
  input  logic                  in_rst_n,
  input  logic                  alloc_valid,
  input  rob_pkg::rename_req_t  rename_req,
  output rob_pkg::rob_idx_t     next_rob_index,
  output logic                  rob_ready,
  input  logic                  fu_valid,
  input  rob_pkg::fu_result_t   fu_result,
  output logic                  rs_valid,
  output rob_pkg::rs_dispatch_t rs_dispatch,
  output logic                  bcast_valid,
  output rob_pkg::broadcast_t   bcast,
  output logic                  commit_valid,
  output rob_pkg::commit_t      commit
);

  rob_pkg::rob_entry_t       rob_q [rob_pkg::ROB_DEPTH];
  rob_pkg::rob_idx_t         head_q;  // Oldest in flight
  rob_pkg::rob_idx_t         tail_q;  // Next slot to hand out
  logic [rob_pkg::ROB_IDX_W:0] count_q;

  // Rename request held for one cycle on its way to the RS
  logic                 req_valid_q;
  rob_pkg::rename_req_t req_q;
  rob_pkg::rob_idx_t    req_dst_q;

  logic              bcast_valid_q;
  rob_pkg::rob_idx_t bcast_idx_q;
  logic              retire;

  function automatic rob_pkg::gpr_opnd_t resolve_gpr(
    input rob_pkg::gpr_opnd_t  opnd,
    input rob_pkg::rob_entry_t entry
  );
    rob_pkg::gpr_opnd_t res;
    res = opnd;
    if (!opnd.valid && entry.done) begin
      res.valid = 1'b1;
      res.value = entry.value;
    end
    return res;
  endfunction

  assign next_rob_index = tail_q;
  assign rob_ready      = count_q < rob_pkg::ROB_DEPTH;
  assign retire         = rob_q[head_q].done;  // Free slots always read not done

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
        rob_q[i].done <= 1'b0;
      end
    end else begin
      if (alloc_valid) begin
        rob_q[tail_q].done      <= 1'b0;
        rob_q[tail_q].gpr_index <= rename_req.dst;
        rob_q[tail_q].set_nzcv  <= rename_req.set_nzcv;
        rob_q[tail_q].nzcv      <= '0;
      end
      if (fu_valid) begin
        rob_q[fu_result.rob_index].done  <= 1'b1;
        rob_q[fu_result.rob_index].value <= fu_result.value;
        if (fu_result.set_nzcv) begin
          rob_q[fu_result.rob_index].nzcv <= fu_result.nzcv;
        end
      end
      if (retire) begin
        rob_q[head_q].done <= 1'b0;
      end
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      head_q        <= '0;
      tail_q        <= '0;
      count_q       <= '0;
      req_valid_q   <= 1'b0;
      bcast_valid_q <= 1'b0;
    end else begin
      if (alloc_valid) begin
        tail_q <= tail_q + 1'b1;
      end
      if (retire) begin
        head_q <= head_q + 1'b1;
      end
      case ({alloc_valid, retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      req_valid_q   <= alloc_valid;
      bcast_valid_q <= fu_valid;
    end
  end

  always_ff @(posedge in_clk) begin
    if (alloc_valid) begin
      req_q     <= rename_req;
      req_dst_q <= tail_q;
    end
    if (fu_valid) begin
      bcast_idx_q <= fu_result.rob_index;
    end
  end

  assign rs_valid = req_valid_q;

  always_comb begin
    rs_dispatch.dst_rob_index = req_dst_q;
    rs_dispatch.src1          = resolve_gpr(req_q.src1, rob_q[req_q.src1.rob_index]);
    rs_dispatch.src2          = resolve_gpr(req_q.src2, rob_q[req_q.src2.rob_index]);
    rs_dispatch.nzcv          = req_q.nzcv;
    if (!req_q.nzcv.valid && rob_q[req_q.nzcv.rob_index].done) begin
      rs_dispatch.nzcv.valid = 1'b1;
      rs_dispatch.nzcv.flags = rob_q[req_q.nzcv.rob_index].nzcv;
    end
    rs_dispatch.set_nzcv  = req_q.set_nzcv;
    rs_dispatch.uses_nzcv = req_q.uses_nzcv;
    rs_dispatch.fu_id     = req_q.fu_id;
    rs_dispatch.fu_op     = req_q.fu_op;
    rs_dispatch.cond      = req_q.cond;
  end

  // Result is read back from the entry one cycle after capture
  assign bcast_valid = bcast_valid_q;

  always_comb begin
    bcast.rob_index = bcast_idx_q;
    bcast.value     = rob_q[bcast_idx_q].value;
    bcast.set_nzcv  = rob_q[bcast_idx_q].set_nzcv;
    bcast.nzcv      = rob_q[bcast_idx_q].nzcv;
  end

  assign commit_valid = retire;

  always_comb begin
    commit.gpr_index = rob_q[head_q].gpr_index;
    commit.value     = rob_q[head_q].value;
    commit.set_nzcv  = rob_q[head_q].set_nzcv;
    commit.nzcv      = rob_q[head_q].nzcv;
    commit.rob_index = head_q;
  end

endmodule

/* hw/rename_stage.sv */
`timescale 1ns/100ps

module rename_stage (
  input  logic                  in_clk,
  input  logic                  in_rst_n,
  input  logic                  issue_valid,
  input  rob_pkg::issue_instr_t issue_instr,
  output logic                  issue_ready,
  input  logic                  rob_ready,
  input  rob_pkg::rob_idx_t     next_rob_index,
  output logic                  alloc_valid,
  output rob_pkg::rename_req_t  rename_req,
  output rob_pkg::gpr_idx_t     rd_src1_idx,
  output rob_pkg::gpr_idx_t     rd_src2_idx,
  input  rob_pkg::gpr_val_t     rd_src1_value,
  input  rob_pkg::gpr_val_t     rd_src2_value,
  input  rob_pkg::nzcv_t        rd_nzcv,
  input  logic                  commit_valid,
  input  rob_pkg::commit_t      commit
);

  // Register status table
  logic [rob_pkg::GPR_COUNT-1:0] gpr_pending;
  rob_pkg::rob_idx_t             gpr_tag [rob_pkg::GPR_COUNT];
  logic                          nzcv_pending;
  rob_pkg::rob_idx_t             nzcv_tag;

  function automatic rob_pkg::gpr_opnd_t lookup_gpr(
    input logic              pending,
    input rob_pkg::rob_idx_t tag,
    input rob_pkg::gpr_val_t rf_value,
    input logic              bypass_hit,
    input rob_pkg::gpr_val_t bypass_value
  );
    rob_pkg::gpr_opnd_t opnd;
    opnd.rob_index = tag;
    opnd.valid     = !pending || bypass_hit;
    opnd.value     = pending ? bypass_value : rf_value;
    return opnd;
  endfunction

  assign issue_ready = rob_ready;
  assign alloc_valid = issue_valid && rob_ready;
  assign rd_src1_idx = issue_instr.src1;
  assign rd_src2_idx = issue_instr.src2;

  always_comb begin
    rename_req.dst  = issue_instr.dst;
    // Commit in flight this cycle counts as resolved
    rename_req.src1 = lookup_gpr(gpr_pending[issue_instr.src1], gpr_tag[issue_instr.src1],
                                 rd_src1_value,
                                 commit_valid && commit.rob_index == gpr_tag[issue_instr.src1],
                                 commit.value);
    rename_req.src2 = lookup_gpr(gpr_pending[issue_instr.src2], gpr_tag[issue_instr.src2],
                                 rd_src2_value,
                                 commit_valid && commit.rob_index == gpr_tag[issue_instr.src2],
                                 commit.value);

    rename_req.nzcv.rob_index = nzcv_tag;
    rename_req.nzcv.valid     = !nzcv_pending || (commit_valid && commit.rob_index == nzcv_tag);
    rename_req.nzcv.flags     = nzcv_pending ? commit.nzcv : rd_nzcv;

    rename_req.set_nzcv  = issue_instr.set_nzcv;
    rename_req.uses_nzcv = issue_instr.uses_nzcv;
    rename_req.fu_id     = issue_instr.fu_id;
    rename_req.fu_op     = issue_instr.fu_op;
    rename_req.cond      = issue_instr.cond;
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      gpr_pending  <= '0;
      nzcv_pending <= 1'b0;
      nzcv_tag     <= '0;
      for (int i = 0; i < rob_pkg::GPR_COUNT; i++) begin
        gpr_tag[i] <= '0;
      end
    end else begin
      // Only the latest producer may clear the entry
      if (commit_valid && gpr_tag[commit.gpr_index] == commit.rob_index) begin
        gpr_pending[commit.gpr_index] <= 1'b0;
      end
      if (commit_valid && commit.set_nzcv && nzcv_tag == commit.rob_index) begin
        nzcv_pending <= 1'b0;
      end
      // Later in the block, so a new mapping beats the clear
      if (alloc_valid) begin
        gpr_pending[issue_instr.dst] <= 1'b1;
        gpr_tag[issue_instr.dst]     <= next_rob_index;
        if (issue_instr.set_nzcv) begin
          nzcv_pending <= 1'b1;
          nzcv_tag     <= next_rob_index;
        end
      end
    end
  end

endmodule

/* hw/rob_pkg.sv */
package rob_pkg;

  localparam int GPR_W     = 64;
  localparam int GPR_COUNT = 32;
  localparam int GPR_IDX_W = $clog2(GPR_COUNT);
  localparam int ROB_DEPTH = 8;
  localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

  typedef logic [3:0]           nzcv_t;  // N Z C V, N in the msb
  typedef logic [1:0]           fu_t;
  typedef logic [3:0]           fu_op_t;
  typedef logic [3:0]           cond_t;
  typedef logic [GPR_IDX_W-1:0] gpr_idx_t;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [GPR_W-1:0]     gpr_val_t;

  // Decoded instruction as it arrives from decode
  typedef struct packed {
    gpr_idx_t dst;
    gpr_idx_t src1;
    gpr_idx_t src2;
    logic     set_nzcv;
    logic     uses_nzcv;
    fu_t      fu_id;
    fu_op_t   fu_op;
    cond_t    cond;
  } issue_instr_t;

  // Either a value or the ROB slot that will produce it
  typedef struct packed {
    logic     valid;
    gpr_val_t value;
    rob_idx_t rob_index;
  } gpr_opnd_t;

  typedef struct packed {
    logic     valid;
    nzcv_t    flags;
    rob_idx_t rob_index;
  } nzcv_opnd_t;

  typedef struct packed {
    gpr_idx_t   dst;
    gpr_opnd_t  src1;
    gpr_opnd_t  src2;
    nzcv_opnd_t nzcv;
    logic       set_nzcv;
    logic       uses_nzcv;
    fu_t        fu_id;
    fu_op_t     fu_op;
    cond_t      cond;
  } rename_req_t;

  typedef struct packed {
    rob_idx_t   dst_rob_index;
    gpr_opnd_t  src1;
    gpr_opnd_t  src2;
    nzcv_opnd_t nzcv;
    logic       set_nzcv;
    logic       uses_nzcv;
    fu_t        fu_id;
    fu_op_t     fu_op;
    cond_t      cond;
  } rs_dispatch_t;

  typedef struct packed {
    rob_idx_t rob_index;
    gpr_val_t value;
    logic     set_nzcv;
    nzcv_t    nzcv;
  } fu_result_t;

  typedef struct packed {
    rob_idx_t rob_index;
    gpr_val_t value;
    logic     set_nzcv;
    nzcv_t    nzcv;
  } broadcast_t;

  typedef struct packed {
    gpr_idx_t gpr_index;
    gpr_val_t value;
    logic     set_nzcv;
    nzcv_t    nzcv;
    rob_idx_t rob_index;
  } commit_t;

  typedef struct packed {
    logic     done;
    gpr_idx_t gpr_index;
    gpr_val_t value;
    logic     set_nzcv;
    nzcv_t    nzcv;
  } rob_entry_t;

endpackage
